// File: verification/dcacheTests.txt
// op addr byteSelect wdata expected, all hex; op 0 reads, op 1 writes
// expected is checked on reads only, memory byte a holds a[7:0] ^ a5
0 010 0 00000000 b6b7b4b5
0 018 0 00000000 bebfbcbd
1 014 5 11223344 00000000
0 014 0 00000000 b222b044
0 110 0 00000000 b6b7b4b5
0 014 0 00000000 b222b044
1 110 f deadbeef 00000000
0 010 0 00000000 b6b7b4b5
0 110 0 00000000 deadbeef
0 200 0 00000000 a6a7a4a5
1 324 8 7f000000 00000000
0 03c 0 00000000 9a9b9899
1 448 3 0000cafe 00000000
0 550 0 00000000 f6f7f4f5
0 664 0 00000000 c2c3c0c1
1 778 6 00abcd00 00000000
0 88c 0 00000000 2a2b2829
0 990 0 00000000 36373435
0 aa4 0 00000000 02030001
1 bb8 f 12345678 00000000
0 ccc 0 00000000 6a6b6869
0 dd0 0 00000000 76777475
0 ee4 0 00000000 42434041
0 ff8 0 00000000 5e5f5c5d
0 324 0 00000000 7f838081
0 024 0 00000000 82838081
0 324 0 00000000 7f838081
0 048 0 00000000 eeefeced
0 448 0 00000000 eeefcafe
0 778 0 00000000 deabcddd
0 0b8 0 00000000 1e1f1c1d
0 bb8 0 00000000 12345678

// File: dcacheSubsystem.f
+incdir+verilog
verilog/dcacheTypesPkg.sv
verilog/memBusPkg.sv
verilog/dcacheController.sv
verilog/dcacheArray.sv
verilog/dataMemory.sv
verilog/dcacheTop.sv
verification/dcacheTb.sv

// File: Bender.yml
package:
  name: dcacheSubsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcacheTypesPkg.sv
      - verilog/memBusPkg.sv
      - verilog/dcacheController.sv
      - verilog/dcacheArray.sv
      - verilog/dataMemory.sv
      - verilog/dcacheTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/dcacheTb.sv

// File: verification/dcacheTb.sv
//////////////////////////////
// requests and expected words come from verification/dcacheTests.txt
// run from the project root so that path resolves
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dcache_params.svh"

module dcacheTb
	import dcacheTypesPkg::*;
();

	localparam int ClockPeriod = 40;
	localparam int MaxTests = 64;
	localparam logic [31:0] LfsrSeed = 32'h4c68e2f9;
	localparam logic [31:0] LfsrTaps = 32'h80200003;

	logic clock;
	logic reset;
	cpuReqT req;
	logic stall;
	logic [`DWORD_SIZE_BITS-1:0] dout;
	ctrlStateT ctrlState;

	cpuReqT testReq [MaxTests];
	logic [`DWORD_SIZE_BITS-1:0] testExpect [MaxTests];
	int testCount;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	logic [31:0] lfsr;

	// direct-mapped tag model, predicts hits
	logic [`DTAG_SIZE-1:0] modelTag [1 << `DINDEX_SIZE];
	logic [(1 << `DINDEX_SIZE)-1:0] modelValid;

	dcacheTop dut_i (
		.clock(clock),
		.reset(reset),
		.req(req),
		.stall(stall),
		.dout(dout)
	);

	assign ctrlState = dut_i.controller_i.state;

	initial begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles, controller in %s", cycleCount, ctrlState.name());
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LfsrTaps;
		end
		return state >> 1;
	endfunction

	// one LFSR step per bit taken
	task automatic takeRandomBits(input int width, output int value);
		value = 0;
		for (int i = 0; i < width; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
	endtask

	task automatic checkWord(input string name, input logic [`DWORD_SIZE_BITS-1:0] actual,
		input logic [`DWORD_SIZE_BITS-1:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkStall(input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: stall is %b, expected %b", $time, actual, expected);
		end
	endtask

	task automatic loadTests();
		int fd;
		int fields;
		string line;
		logic [31:0] op, addr, sel, wdata, expectWord;
		testCount = 0;
		fd = $fopen("verification/dcacheTests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			fields = $fgets(line, fd);
			// skip comment and blank lines
			if (line.len() > 1 && line[0] != "/" && testCount < MaxTests) begin
				fields = $sscanf(line, "%h %h %h %h %h", op, addr, sel, wdata, expectWord);
				if (fields == 5) begin
					testReq[testCount].ren = (op == 0);
					testReq[testCount].wen = (op != 0);
					testReq[testCount].addr = addr[`DADDR_SIZE-1:0];
					testReq[testCount].byteSelect = sel[`DWORD_SIZE-1:0];
					testReq[testCount].wdata = wdata;
					testExpect[testCount] = expectWord;
					testCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	// no request, stall must stay low
	task automatic idleCycles(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			req <= '0;
			#(ClockPeriod / 4);
			checkStall(stall, 1'b0);
		end
	endtask

	task automatic runTest(input int n);
		logic [`DINDEX_SIZE-1:0] idx;
		logic [`DTAG_SIZE-1:0] tag;
		logic predictedHit;
		logic stallSeen;
		logic [`DWORD_SIZE_BITS-1:0] doutSeen;
		int errorsBefore;
		tag = testReq[n].addr[`DADDR_SIZE-1 -: `DTAG_SIZE];
		idx = testReq[n].addr[`DADDR_SIZE-`DTAG_SIZE-1 -: `DINDEX_SIZE];
		predictedHit = modelValid[idx] && (modelTag[idx] == tag);
		errorsBefore = errorCount;
		@(negedge clock);
		req <= testReq[n];
		// sample a quarter period before the rising edge
		#(ClockPeriod / 4);
		checkStall(stall, !predictedHit);
		stallSeen = stall;
		doutSeen = dout;
		while (stallSeen) begin
			@(negedge clock);
			#(ClockPeriod / 4);
			stallSeen = stall;
			doutSeen = dout;
		end
		@(posedge clock);
		if (testReq[n].ren) begin
			checkWord("dout", doutSeen, testExpect[n]);
		end
		modelValid[idx] = 1'b1;
		modelTag[idx] = tag;
		$display("test %0d: %s addr %h %s", n + 1, testReq[n].ren ? "read " : "write",
			testReq[n].addr, (errorCount == errorsBefore) ? "ok" : "mismatch");
	endtask

	initial begin
		int gap;
		reset = 1'b0;
		req = '0;
		lfsr = LfsrSeed;
		modelValid = '0;
		loadTests();
		cycleLimit = testCount * (2 * `DMEM_LATENCY + 8) + 20;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;
		idleCycles(2);
		for (int n = 0; n < testCount; n++) begin
			runTest(n);
			takeRandomBits(2, gap);
			idleCycles(gap);
		end
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0 && testCount > 0) begin
			$display("Simulation passed");
		end else begin
			if (testCount == 0) begin
				$display("no tests were read");
			end
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/dcacheTop.sv
//////////////////////////////
// pipeline port: hold request until stall is low
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dcache_params.svh"

module dcacheTop
	import dcacheTypesPkg::*;
	import memBusPkg::*;
(
	input  logic clock,
	input  logic reset,
	input  cpuReqT req,
	output logic stall,
	output logic [`DWORD_SIZE_BITS-1:0] dout
);

	logic hit;
	logic victimDirty;
	logic [`DBLOCK_SIZE_BITS-1:0] victimBlock;
	logic [`DMEM_BLOCK_ADDR_SIZE-1:0] victimBlockAddr;
	arrayCtrlT arrayCtrl;
	memReqT memReq;
	memRespT memResp;

	dcacheController controller_i (
		.clock(clock),
		.reset(reset),
		.req(req),
		.hit(hit),
		.victimDirty(victimDirty),
		.victimBlock(victimBlock),
		.victimBlockAddr(victimBlockAddr),
		.memResp(memResp),
		.stall(stall),
		.arrayCtrl(arrayCtrl),
		.memReq(memReq)
	);

	dcacheArray array_i (
		.clock(clock),
		.reset(reset),
		.req(req),
		.arrayCtrl(arrayCtrl),
		.hit(hit),
		.victimDirty(victimDirty),
		.victimBlock(victimBlock),
		.victimBlockAddr(victimBlockAddr),
		.dout(dout)
	);

	dataMemory memory_i (
		.clock(clock),
		.reset(reset),
		.memReq(memReq),
		.memResp(memResp)
	);

endmodule

`default_nettype wire

// File: verilog/dataMemory.sv
//////////////////////////////
// fixed latency, one request at a time
// contents come from a rule at reset
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dcache_params.svh"

module dataMemory
	import memBusPkg::*;
(
	input  logic clock,
	input  logic reset,
	input  memReqT memReq,
	output memRespT memResp
);

	localparam int Blocks = 1 << `DMEM_BLOCK_ADDR_SIZE;
	localparam int CntW = $clog2(`DMEM_LATENCY + 1);

	logic [`DBLOCK_SIZE_BITS-1:0] mem [Blocks];
	logic [`DBLOCK_SIZE_BITS-1:0] rdataReg;
	logic [CntW-1:0] count;
	logic busy, fired, opWrite;
	logic readyReg, doneReg;
	logic active, startReq, fire;

	assign active = memReq.ren | memReq.wen;
	// a change of direction without a gap also starts a new access
	assign startReq = active && (!busy || (opWrite != memReq.wen));
	assign fire = busy && !fired && !startReq && (count >= CntW'(`DMEM_LATENCY - 1));

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
			fired <= 1'b0;
			opWrite <= 1'b0;
			count <= '0;
			readyReg <= 1'b0;
			doneReg <= 1'b0;
		end else begin
			readyReg <= fire && !opWrite;
			doneReg <= fire && opWrite;
			if (!active) begin
				busy <= 1'b0;
				fired <= 1'b0;
				count <= '0;
			end else if (startReq) begin
				busy <= 1'b1;
				fired <= 1'b0;
				opWrite <= memReq.wen;
				count <= CntW'(1);
			end else if (fire) begin
				fired <= 1'b1;
			end else if (!fired) begin
				count <= count + 1'b1;
			end
		end
	end

	// byte at address a holds a[7:0] ^ 8'hA5
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < Blocks; i++) begin
				for (int j = 0; j < `DBLOCK_SIZE; j++) begin
					mem[i][j * 8 +: 8] <= 8'(i * `DBLOCK_SIZE + j) ^ 8'hA5;
				end
			end
		end else if (fire && opWrite) begin
			mem[memReq.blockAddr] <= memReq.wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (fire && !opWrite) begin
			rdataReg <= mem[memReq.blockAddr];
		end
	end

	assign memResp.readReady = readyReg;
	assign memResp.writeDone = doneReg;
	assign memResp.rdata = rdataReg;

	memOneOp: assert property (@(posedge clock) disable iff (!reset)
		!(memReq.ren && memReq.wen));

endmodule

`default_nettype wire

// File: verilog/dcacheArray.sv
//////////////////////////////
// direct mapped, one block per index
// dout is only meaningful on a hit
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dcache_params.svh"

module dcacheArray
	import dcacheTypesPkg::*;
(
	input  logic clock,
	input  logic reset,
	input  cpuReqT req,
	input  arrayCtrlT arrayCtrl,
	output logic hit,
	output logic victimDirty,
	output logic [`DBLOCK_SIZE_BITS-1:0] victimBlock,
	output logic [`DMEM_BLOCK_ADDR_SIZE-1:0] victimBlockAddr,
	output logic [`DWORD_SIZE_BITS-1:0] dout
);

	localparam int Lines = 1 << `DINDEX_SIZE;
	localparam int ByteOffBits = $clog2(`DWORD_SIZE);
	localparam int WordOffBits = $clog2(`DBLOCK_SIZE / `DWORD_SIZE);

	logic [`DTAG_SIZE-1:0] tags [Lines];
	logic [`DBLOCK_SIZE_BITS-1:0] blocks [Lines];
	logic [Lines-1:0] valid;
	logic [Lines-1:0] dirty;

	logic [`DTAG_SIZE-1:0] reqTag;
	logic [`DINDEX_SIZE-1:0] reqIndex;
	logic [WordOffBits-1:0] wordOff;
	logic writeHit;

	// address fields, tag on top
	assign reqTag = req.addr[`DADDR_SIZE-1 -: `DTAG_SIZE];
	assign reqIndex = req.addr[ByteOffBits + WordOffBits +: `DINDEX_SIZE];
	assign wordOff = req.addr[ByteOffBits +: WordOffBits];

	assign hit = valid[reqIndex] && (tags[reqIndex] == reqTag);
	assign writeHit = req.wen && hit && !arrayCtrl.fillEn;

	assign victimDirty = valid[reqIndex] && dirty[reqIndex];
	assign victimBlock = blocks[reqIndex];
	assign victimBlockAddr = {tags[reqIndex], reqIndex};

	assign dout = hit ? blocks[reqIndex][wordOff * `DWORD_SIZE_BITS +: `DWORD_SIZE_BITS] : '0;

	// line status
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (arrayCtrl.fillEn) begin
			valid[reqIndex] <= 1'b1;
			dirty[reqIndex] <= 1'b0;
		end else if (writeHit) begin
			dirty[reqIndex] <= 1'b1;
		end
	end

	// tags and data, fill replaces the whole block
	always_ff @(posedge clock) begin
		if (arrayCtrl.fillEn) begin
			tags[reqIndex] <= reqTag;
			blocks[reqIndex] <= arrayCtrl.fillBlock;
		end else if (writeHit) begin
			for (int b = 0; b < `DWORD_SIZE; b++) begin
				if (req.byteSelect[b]) begin
					blocks[reqIndex][wordOff * `DWORD_SIZE_BITS + b * 8 +: 8] <=
						req.wdata[b * 8 +: 8];
				end
			end
		end
	end

	// fill only follows a miss, so no write can hit in that cycle
	fillNotWriteHit: assert property (@(posedge clock) disable iff (!reset)
		!(arrayCtrl.fillEn && req.wen && hit));

endmodule

`default_nettype wire

// File: verilog/dcacheController.sv
//////////////////////////////
// one outstanding miss at a time
// request must stay unchanged while stall is high
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dcache_params.svh"

module dcacheController
	import dcacheTypesPkg::*;
	import memBusPkg::*;
(
	input  logic clock,
	input  logic reset,
	input  cpuReqT req,
	input  logic hit,
	input  logic victimDirty,
	input  logic [`DBLOCK_SIZE_BITS-1:0] victimBlock,
	input  logic [`DMEM_BLOCK_ADDR_SIZE-1:0] victimBlockAddr,
	input  memRespT memResp,
	output logic stall,
	output arrayCtrlT arrayCtrl,
	output memReqT memReq
);

	ctrlStateT state, nextState;
	logic reqValid;
	logic [`DBLOCK_SIZE_BITS-1:0] fillData;

	assign reqValid = req.ren | req.wen;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= ctrlIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		unique case (state)
			ctrlIdle: begin
				if (reqValid && !hit) begin
					nextState = ctrlMiss;
				end
			end
			ctrlMiss: begin
				nextState = victimDirty ? ctrlWriteBack : ctrlMemRead;
			end
			ctrlWriteBack: begin
				if (memResp.writeDone) begin
					nextState = ctrlMemRead;
				end
			end
			ctrlMemRead: begin
				if (memResp.readReady) begin
					nextState = ctrlFill;
				end
			end
			ctrlFill: begin
				nextState = ctrlIdle;
			end
			default: nextState = ctrlIdle;
		endcase
	end

	// new block is held one cycle until the fill state writes it
	always_ff @(posedge clock) begin
		if (state == ctrlMemRead && memResp.readReady) begin
			fillData <= memResp.rdata;
		end
	end

	// a miss stalls already in idle so the access cannot complete
	assign stall = (state != ctrlIdle) || (reqValid && !hit);

	assign arrayCtrl.fillEn = (state == ctrlFill);
	assign arrayCtrl.fillBlock = fillData;

	assign memReq.ren = (state == ctrlMemRead);
	assign memReq.wen = (state == ctrlWriteBack);
	// write-back goes to the victim, the fetch to the requested block
	assign memReq.blockAddr = (state == ctrlWriteBack) ? victimBlockAddr
		: req.addr[`DADDR_SIZE-1 -: `DMEM_BLOCK_ADDR_SIZE];
	assign memReq.wdata = victimBlock;

	memOneOp: assert property (@(posedge clock) disable iff (!reset)
		!(memReq.ren && memReq.wen));

	stallOutsideIdle: assert property (@(posedge clock) disable iff (!reset)
		(state != ctrlIdle) |-> stall);

	// the held request must hit once the block is installed
	hitAfterFill: assert property (@(posedge clock) disable iff (!reset)
		(state == ctrlFill) |=> (state == ctrlIdle && !stall));

endmodule

`default_nettype wire

// File: verilog/memBusPkg.sv
//////////////////////////////
// block-wide memory bus, no back-pressure
//////////////////////////////
`default_nettype none

`include "dcache_params.svh"

package memBusPkg;

	typedef struct packed {
		logic ren;
		logic wen;
		logic [`DMEM_BLOCK_ADDR_SIZE-1:0] blockAddr;
		logic [`DBLOCK_SIZE_BITS-1:0] wdata;
	} memReqT;

	// strobes are single cycle
	typedef struct packed {
		logic readReady;
		logic writeDone;
		logic [`DBLOCK_SIZE_BITS-1:0] rdata;
	} memRespT;

endpackage

`default_nettype wire

// File: verilog/dcacheTypesPkg.sv
//////////////////////////////
// pipeline request and controller-to-array types
//////////////////////////////
`default_nettype none

`include "dcache_params.svh"

package dcacheTypesPkg;

	// one pipeline access, held steady while stall is high
	typedef struct packed {
		logic ren;
		logic wen;
		logic [`DADDR_SIZE-1:0] addr;
		logic [`DWORD_SIZE-1:0] byteSelect;
		logic [`DWORD_SIZE_BITS-1:0] wdata;
	} cpuReqT;

	// miss handling states
	typedef enum logic [2:0] {
		ctrlIdle      = 3'b000,
		ctrlMiss      = 3'b001,
		ctrlMemRead   = 3'b010,
		ctrlWriteBack = 3'b011,
		ctrlFill      = 3'b100
	} ctrlStateT;

	// block install after a memory read
	typedef struct packed {
		logic fillEn;
		logic [`DBLOCK_SIZE_BITS-1:0] fillBlock;
	} arrayCtrlT;

endpackage

`default_nettype wire

// File: verilog/dcache_params.svh
//////////////////////////////
// cache geometry and memory timing, all in bytes unless noted
// word and block sizes must stay powers of two
//////////////////////////////
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// byte address width
`define DADDR_SIZE 12

// word size in bytes and bits
`define DWORD_SIZE 4
`define DWORD_SIZE_BITS 32

// block size in bytes and bits
`define DBLOCK_SIZE 16
`define DBLOCK_SIZE_BITS 128

// direct-mapped split of the address above the block offset
`define DINDEX_SIZE 4
`define DTAG_SIZE 4
`define DMEM_BLOCK_ADDR_SIZE 8

// cycles from memory request to done strobe
`define DMEM_LATENCY 4

`endif
